// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= sg_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(filter-out +%,$(shell cat src.f)) $(wildcard design/*.svh)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) src.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f src.f

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// ==== design/psg_mixer.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "sg_settings.svh"

module psg_mixer (
	input  logic       sys_clk,
	input  logic       arst_n,
	input  logic       level [`SG_TONE_CH],
	input  logic [3:0] atten [`SG_TONE_CH],
	output logic [5:0] audio
);

	logic [5:0] sum;

	// ************************************************************
	// channel sum
	// ************************************************************

	// linear volume, 15 minus attenuation per channel.
	always_comb begin
		sum = 6'd0;
		for (int i = 0; i < `SG_TONE_CH; i++) begin
			if (level[i])
				sum = sum + {2'b00, 4'hf - atten[i]};
		end
	end

	// ************************************************************
	// output register
	// ************************************************************

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n)
			audio <= 6'd0;
		else
			audio <= sum; // 45 at most.
	end

endmodule

`default_nettype wire

// ==== design/psg_regs.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "sg_settings.svh"

module psg_regs import sg_pkg::*; (
	input  logic          sys_clk,
	input  logic          arst_n,
	input  logic          wr,
	input  psg_byte_u     wbyte,
	output logic          tick,
	output psg_tone_cfg_t cfg [`SG_TONE_CH]
);

	localparam int PW = $clog2(`SG_PSG_PRESCALE);

	logic [PW-1:0] pre_cnt;
	logic [1:0]    chan_q;      // latched target.
	logic          atten_sel_q;
	logic [1:0]    tgt_chan;
	logic          tgt_atten;
	logic [3:0]    atten_val;

	// ************************************************************
	// prescaler
	// ************************************************************

	assign tick = (pre_cnt == PW'(`SG_PSG_PRESCALE - 1));

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n)
			pre_cnt <= '0;
		else if (tick)
			pre_cnt <= '0;
		else
			pre_cnt <= pre_cnt + 1'b1;
	end

	// ************************************************************
	// register writes
	// ************************************************************

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			chan_q      <= 2'd0;
			atten_sel_q <= 1'b0;
		end else if (wr && wbyte.latch.is_latch) begin
			chan_q      <= wbyte.latch.chan;
			atten_sel_q <= wbyte.latch.is_atten;
		end
	end

	// a data byte goes where the last latch pointed.
	assign tgt_chan  = wbyte.latch.is_latch ? wbyte.latch.chan : chan_q;
	assign tgt_atten = wbyte.latch.is_latch ? wbyte.latch.is_atten : atten_sel_q;
	assign atten_val = wbyte.latch.is_latch ? wbyte.latch.data : wbyte.data.hi[3:0];

	// channel 3 (noise) has no slot here.
	for (genvar i = 0; i < `SG_TONE_CH; i++) begin : g_ch
		psg_tone_cfg_t cfg_q;
		logic          hit;

		assign hit = wr && (tgt_chan == 2'(i));

		always_ff @(posedge sys_clk or negedge arst_n) begin
			if (!arst_n) begin
				cfg_q.period <= '0;
				cfg_q.atten  <= 4'hf; // silent.
			end else if (hit) begin
				if (tgt_atten)
					cfg_q.atten <= atten_val;
				else if (wbyte.latch.is_latch)
					cfg_q.period[3:0] <= wbyte.latch.data;
				else
					cfg_q.period[9:4] <= wbyte.data.hi;
			end
		end

		assign cfg[i] = cfg_q;

		a_cfg_quiet: assert property (@(posedge sys_clk) disable iff (!arst_n)
			!wr |=> $stable(cfg[i]));
	end

endmodule

`default_nettype wire

// ==== design/psg_tone.sv ====
`timescale 1ns/100ps
`default_nettype none

module psg_tone import sg_pkg::*; (
	input  logic          sys_clk,
	input  logic          arst_n,
	input  logic          tick,
	input  psg_tone_cfg_t cfg,
	output logic          level,
	output logic [3:0]    atten
);

	logic [9:0] cnt;
	logic       level_q;
	logic       low_period;
	logic       reload;

	assign low_period = (cfg.period < 10'd2); // 0 and 1 give a flat high.
	assign reload     = tick && !low_period && (cnt == 10'd0);

	// ************************************************************
	// down-counter
	// ************************************************************

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt     <= 10'd0;
			level_q <= 1'b1;
		end else if (tick) begin
			if (low_period) begin
				cnt     <= 10'd0;
				level_q <= 1'b1;
			end else if (cnt == 10'd0) begin
				// P-1 more ticks to reach zero, so one edge every P ticks.
				cnt     <= cfg.period - 10'd1;
				level_q <= !level_q;
			end else begin
				cnt <= cnt - 10'd1;
			end
		end
	end

	assign level = low_period || level_q;
	assign atten = cfg.atten;

	a_cnt_range: assert property (@(posedge sys_clk) disable iff (!arst_n)
		reload |=> cnt < $past(cfg.period));

endmodule

`default_nettype wire

// ==== design/sg_bus_decode.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "sg_settings.svh"

module sg_bus_decode import sg_pkg::*; (
	input  logic                  sys_clk,
	input  logic                  arst_n,
	input  sg_bus_req_t           req,
	input  logic                  req_valid,
	output logic                  req_ready,
	output sg_bus_rsp_t           rsp,
	output logic                  rsp_valid,
	input  logic                  rsp_ready,
	output logic [`SG_RAM_AW-1:0] ram_addr,
	output logic [7:0]            ram_wdata,
	output logic                  ram_we,
	output logic                  ram_re,
	input  logic [7:0]            ram_q,
	output logic                  psg_wr,
	output psg_byte_u             psg_byte,
	input  logic [7:0]            joy_a,
	input  logic [7:0]            joy_b
);

	localparam logic [2:0] SRC_ZERO = 3'd0; // write ack.
	localparam logic [2:0] SRC_OPEN = 3'd1;
	localparam logic [2:0] SRC_RAM  = 3'd2;
	localparam logic [2:0] SRC_JOYA = 3'd3;
	localparam logic [2:0] SRC_JOYB = 3'd4;

	logic       accept;
	logic       hit_ram;
	logic       hit_psg;
	logic       hit_joy;
	logic [2:0] src_d;
	logic [2:0] src_q;
	logic       fresh_q;    // response appeared this cycle.
	logic [7:0] rdata_live;
	logic [7:0] rdata_hold;

	assign req_ready = !rsp_valid || rsp_ready;
	assign accept    = req_valid && req_ready;

	// memory decodes on addr[15:14], ports on addr[7:6].
	assign hit_ram = !req.is_io && (req.addr[15:14] == 2'b11);
	assign hit_psg = req.is_io && (req.addr[7:6] == 2'b01);
	assign hit_joy = req.is_io && (req.addr[7:6] == 2'b11);

	assign ram_addr  = req.addr[`SG_RAM_AW-1:0]; // upper bits mirror.
	assign ram_wdata = req.wdata;
	assign ram_we    = accept && hit_ram && req.is_write;
	assign ram_re    = accept && hit_ram && !req.is_write;
	assign psg_wr    = accept && hit_psg && req.is_write;
	assign psg_byte  = req.wdata;

	always_comb begin
		if (req.is_write)
			src_d = SRC_ZERO;
		else if (hit_ram)
			src_d = SRC_RAM;
		else if (hit_joy)
			src_d = req.addr[0] ? SRC_JOYB : SRC_JOYA;
		else
			src_d = SRC_OPEN;
	end

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			rsp_valid <= 1'b0;
			fresh_q   <= 1'b0;
			src_q     <= SRC_ZERO;
		end else begin
			fresh_q <= accept;
			if (accept) begin
				rsp_valid <= 1'b1;
				src_q     <= src_d;
			end else if (rsp_ready) begin
				rsp_valid <= 1'b0;
			end
		end
	end

	always_comb begin
		case (src_q)
			SRC_RAM:  rdata_live = ram_q;
			SRC_JOYA: rdata_live = joy_a;
			SRC_JOYB: rdata_live = joy_b;
			SRC_OPEN: rdata_live = `SG_OPEN_BUS;
			default:  rdata_live = 8'h00;
		endcase
	end

	// freeze the first value, joypads may move while we wait.
	always_ff @(posedge sys_clk) begin
		if (fresh_q)
			rdata_hold <= rdata_live;
	end

	assign rsp.rdata = fresh_q ? rdata_live : rdata_hold;

	a_rsp_hold: assert property (@(posedge sys_clk) disable iff (!arst_n)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

endmodule

`default_nettype wire

// ==== design/sg_pkg.sv ====
`default_nettype none

package sg_pkg;

	// ************************************************************
	// bus side
	// ************************************************************

	// one memory or I/O cycle from the CPU side.
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        is_io;    // port cycle, only addr[7:0] counts.
		logic        is_write;
	} sg_bus_req_t;

	typedef struct packed {
		logic [7:0] rdata;     // 00 for writes.
	} sg_bus_rsp_t;

	// ************************************************************
	// sound generator
	// ************************************************************

	// first byte of a register write.
	typedef struct packed {
		logic       is_latch;  // set.
		logic [1:0] chan;
		logic       is_atten;
		logic [3:0] data;
	} psg_latch_t;

	// follow-up byte for the latched register.
	typedef struct packed {
		logic       is_latch;  // clear.
		logic       spare;
		logic [5:0] hi;
	} psg_data_t;

	// the same byte seen both ways, bit 7 tells which applies.
	typedef union packed {
		psg_latch_t latch;
		psg_data_t  data;
	} psg_byte_u;

	typedef struct packed {
		logic [9:0] period;    // in ticks.
		logic [3:0] atten;     // 15 is silent.
	} psg_tone_cfg_t;

endpackage

`default_nettype wire

// ==== design/sg_settings.svh ====
`ifndef SG_SETTINGS_SVH
`define SG_SETTINGS_SVH

// ************************************************************
// work RAM
// ************************************************************
`define SG_RAM_AW 10           // 1 KiB, mirrored over C000-FFFF.

// ************************************************************
// sound generator
// ************************************************************
`define SG_PSG_PRESCALE 16     // sys_clk cycles per tone tick.
`define SG_TONE_CH 3

// value seen on reads nobody answers.
`define SG_OPEN_BUS 8'hFF

`endif

// ==== design/sg_top.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "sg_settings.svh"

module sg_top import sg_pkg::*; (
	input  logic        sys_clk,
	input  logic        arst_n,
	input  sg_bus_req_t req,
	input  logic        req_valid,
	output logic        req_ready,
	output sg_bus_rsp_t rsp,
	output logic        rsp_valid,
	input  logic        rsp_ready,
	input  logic [7:0]  joy_a,
	input  logic [7:0]  joy_b,
	output logic [5:0]  audio
);

	logic [`SG_RAM_AW-1:0] ram_addr;
	logic [7:0]            ram_wdata;
	logic                  ram_we;
	logic                  ram_re;
	logic [7:0]            ram_q;
	logic                  psg_wr;
	psg_byte_u             psg_byte;
	logic                  tick;
	psg_tone_cfg_t         cfg [`SG_TONE_CH];
	logic                  tone_level [`SG_TONE_CH];
	logic [3:0]            tone_atten [`SG_TONE_CH];

	// ************************************************************
	// bus side
	// ************************************************************

	sg_bus_decode u_decode (
		.sys_clk   (sys_clk),
		.arst_n    (arst_n),
		.req       (req),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.rsp       (rsp),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.ram_addr  (ram_addr),
		.ram_wdata (ram_wdata),
		.ram_we    (ram_we),
		.ram_re    (ram_re),
		.ram_q     (ram_q),
		.psg_wr    (psg_wr),
		.psg_byte  (psg_byte),
		.joy_a     (joy_a),
		.joy_b     (joy_b)
	);

	sg_work_ram u_ram (
		.sys_clk (sys_clk),
		.addr    (ram_addr),
		.wdata   (ram_wdata),
		.we      (ram_we),
		.re      (ram_re),
		.q       (ram_q)
	);

	// ************************************************************
	// sound generator
	// ************************************************************

	psg_regs u_regs (
		.sys_clk (sys_clk),
		.arst_n  (arst_n),
		.wr      (psg_wr),
		.wbyte   (psg_byte),
		.tick    (tick),
		.cfg     (cfg)
	);

	for (genvar i = 0; i < `SG_TONE_CH; i++) begin : g_tone
		psg_tone u_tone (
			.sys_clk (sys_clk),
			.arst_n  (arst_n),
			.tick    (tick),
			.cfg     (cfg[i]),
			.level   (tone_level[i]),
			.atten   (tone_atten[i])
		);
	end

	psg_mixer u_mixer (
		.sys_clk (sys_clk),
		.arst_n  (arst_n),
		.level   (tone_level),
		.atten   (tone_atten),
		.audio   (audio)
	);

endmodule

`default_nettype wire

// ==== design/sg_work_ram.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "sg_settings.svh"

module sg_work_ram (
	input  logic                  sys_clk,
	input  logic [`SG_RAM_AW-1:0] addr,
	input  logic [7:0]            wdata,
	input  logic                  we,
	input  logic                  re,
	output logic [7:0]            q
);

	localparam int DEPTH = 1 << `SG_RAM_AW;

	// ************************************************************
	// storage
	// ************************************************************

	logic [7:0] mem [DEPTH];

	always_ff @(posedge sys_clk) begin
		if (we)
			mem[addr] <= wdata;
	end

	// ************************************************************
	// read port
	// ************************************************************

	// q only moves on a read, so it holds while a response waits.
	always_ff @(posedge sys_clk) begin
		if (re)
			q <= mem[addr]; // one cycle latency.
	end

endmodule

`default_nettype wire

// ==== sim/sg_tb.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "sg_settings.svh"

module sg_tb import sg_pkg::*; ();

	localparam int BUS_TIMEOUT   = 64;
	localparam int AUDIO_TIMEOUT = 16;

	typedef enum logic [2:0] {K_BUS, K_JOY, K_BP, K_AUDIO, K_TONE} kind_t;

	typedef struct {
		kind_t       kind;
		sg_bus_req_t req;
		logic [15:0] val;  // rdata, joypads, audio or period.
	} entry_t;

	logic        sys_clk;
	logic        arst_n;
	sg_bus_req_t req;
	logic        req_valid;
	logic        req_ready;
	sg_bus_rsp_t rsp;
	logic        rsp_valid;
	logic        rsp_ready;
	logic [7:0]  joy_a;
	logic [7:0]  joy_b;
	logic [5:0]  audio;

	entry_t     stim_q [$];
	logic       bp_on;
	logic [7:0] ram_model [1 << `SG_RAM_AW];
	logic [3:0] atten_model [`SG_TONE_CH];
	logic [1:0] latch_ch;
	logic       latch_atten;

	sg_top dut_i (.*);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = !sys_clk;
	end

	// ************************************************************
	// checks
	// ************************************************************

	task automatic stop_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "stopped at %0t ns", $time);
	endtask

	task automatic check_rsp(input sg_bus_rsp_t got, input sg_bus_rsp_t exp);
		if (got !== exp)
			stop_run($sformatf("FAIL rsp.rdata: got %h, expected %h", got.rdata, exp.rdata));
	endtask

	task automatic check_audio(input logic [5:0] got, input logic [5:0] exp);
		if (got !== exp)
			stop_run($sformatf("FAIL audio: got %h, expected %h", got, exp));
	endtask

	task automatic check_interval(input int got, input int exp);
		if (got != exp)
			stop_run($sformatf("FAIL audio interval: got %h cycles, expected %h", got, exp));
	endtask

	// ************************************************************
	// stimulus table
	// ************************************************************

	function automatic void add(kind_t kind, sg_bus_req_t r, logic [15:0] val);
		entry_t e;
		e.kind = kind;
		e.req  = r;
		e.val  = val;
		stim_q.push_back(e);
	endfunction

	function automatic void add_bus(logic [15:0] addr, logic [7:0] wdata, logic is_io,
		logic is_write, logic [7:0] exp);
		sg_bus_req_t r;
		r.addr     = addr;
		r.wdata    = wdata;
		r.is_io    = is_io;
		r.is_write = is_write;
		add(K_BUS, r, {8'h00, exp});
	endfunction

	// writes at random addresses and reads back through other mirrors.
	function automatic void ram_round(int n);
		logic [`SG_RAM_AW-1:0] offs [$];
		logic [15:0]           a;
		for (int i = 0; i < n; i++) begin
			a = 16'hC000 | 16'($urandom % 32'h4000);
			ram_model[a[`SG_RAM_AW-1:0]] = 8'($urandom);
			offs.push_back(a[`SG_RAM_AW-1:0]);
			add_bus(a, ram_model[a[`SG_RAM_AW-1:0]], 1'b0, 1'b1, 8'h00);
		end
		foreach (offs[i]) begin
			a = 16'hC000 | 16'($urandom % 32'h4000);
			a[`SG_RAM_AW-1:0] = offs[i];
			add_bus(a, 8'h00, 1'b0, 1'b0, ram_model[offs[i]]);
		end
	endfunction

	// a data byte lands on whatever the last latch selected.
	function automatic void psg_put(psg_byte_u b);
		if (b.latch.is_latch) begin
			latch_ch    = b.latch.chan;
			latch_atten = b.latch.is_atten;
		end
		if (latch_atten && latch_ch != 2'd3)
			atten_model[latch_ch] = b.latch.is_latch ? b.latch.data : b.data.hi[3:0];
		add_bus(16'h007F, b, 1'b1, 1'b1, 8'h00);
	endfunction

	function automatic logic [15:0] level_sum();
		logic [15:0] s;
		s = 16'd0;
		foreach (atten_model[i])
			s = s + 16'(4'hf - atten_model[i]);
		return s;
	endfunction

	function automatic void build_table();
		logic [7:0] port;
		logic [7:0] ja;
		logic [7:0] jb;
		foreach (atten_model[i])
			atten_model[i] = 4'hf;
		latch_ch    = 2'd0;
		latch_atten = 1'b0;
		add(K_AUDIO, '0, level_sum()); // silent out of reset.
		ram_round(12);
		for (int i = 0; i < 6; i++)
			add_bus(16'($urandom % 32'hC000), 8'h00, 1'b0, 1'b0, `SG_OPEN_BUS);
		add_bus(16'hBFFF, 8'h00, 1'b0, 1'b0, `SG_OPEN_BUS);
		for (int p = 0; p < 192; p += 23)
			add_bus({8'($urandom), 8'(p)}, 8'h00, 1'b1, 1'b0, `SG_OPEN_BUS);
		add_bus(16'h00BF, 8'h00, 1'b1, 1'b0, `SG_OPEN_BUS);
		for (int k = 0; k < 2; k++) begin
			ja = 8'($urandom);
			jb = 8'($urandom);
			add(K_JOY, '0, {ja, jb});
			for (int i = 0; i < 4; i++) begin
				port = 8'hC0 | 8'($urandom % 64);
				add_bus({8'h00, port}, 8'h00, 1'b1, 1'b0, port[0] ? jb : ja);
			end
		end
		psg_put(8'h93);                // ch0 atten 3.
		add(K_AUDIO, '0, level_sum());
		psg_put(8'hBF);
		psg_put(8'h07);                // ch1 atten 7 by data byte.
		add(K_AUDIO, '0, level_sum());
		psg_put(8'hD9);
		add(K_AUDIO, '0, level_sum());
		psg_put(8'hF0);                // noise channel.
		psg_put(8'h00);
		add(K_AUDIO, '0, level_sum());
		psg_put(8'hC1);                // ch2 period 1 stays flat high.
		psg_put(8'h00);
		add(K_AUDIO, '0, level_sum());
		add(K_BP, '0, 16'd1);
		ram_round(8);
		add_bus(16'h00C1, 8'h00, 1'b1, 1'b0, jb);
		add_bus(16'h0040, 8'h00, 1'b1, 1'b0, `SG_OPEN_BUS);
		add(K_BP, '0, 16'd0);
		psg_put(8'hBF);
		psg_put(8'hDF);
		psg_put(8'h90);                // ch0 alone at full level.
		add(K_AUDIO, '0, level_sum());
		psg_put(8'h82);
		psg_put(8'h00);
		add(K_TONE, '0, 16'd2);
		psg_put(8'h84);
		psg_put(8'h01);                // period 0x014.
		add(K_TONE, '0, 16'd20);
		psg_put(8'h81);
		psg_put(8'h00);
		add(K_AUDIO, '0, level_sum());
	endfunction

	// ************************************************************
	// drivers
	// ************************************************************

	function automatic logic pick_ready();
		if (bp_on)
			return ($urandom % 3) == 0;
		else
			return 1'b1;
	endfunction

	task automatic bus_cycle(input sg_bus_req_t r, input sg_bus_rsp_t exp);
		int   n;
		logic taken;
		req       = r;
		req_valid = 1'b1;
		taken     = 1'b0;
		for (n = 0; !taken; n++) begin
			if (n == BUS_TIMEOUT)
				stop_run("request was never accepted");
			#1;
			taken = req_ready;
			@(negedge sys_clk);
		end
		req_valid = 1'b0;
		taken     = 1'b0;
		for (n = 0; !taken; n++) begin
			if (n == BUS_TIMEOUT)
				stop_run("response was never taken");
			rsp_ready = pick_ready();
			#1;
			if (!rsp_valid)
				stop_run("response missing or dropped before its transfer");
			check_rsp(rsp, exp); // first cycle and every held one.
			if (req_ready !== rsp_ready)
				stop_run("req_ready open while a response was still waiting");
			taken = rsp_ready;
			@(negedge sys_clk);
		end
		if (rsp_valid)
			stop_run("response repeated after its transfer");
	endtask

	task automatic wait_audio(input logic [5:0] exp);
		int n;
		for (n = 0; audio !== exp && n < AUDIO_TIMEOUT; n++)
			@(negedge sys_clk);
		repeat (2 * `SG_PSG_PRESCALE) begin // spans two ticks so a toggling channel shows.
			check_audio(audio, exp);
			@(negedge sys_clk);
		end
	endtask

	task automatic wait_change(input int limit, output int cycles);
		logic [5:0] start;
		start  = audio;
		cycles = 0;
		while (audio == start) begin
			if (cycles == limit)
				stop_run("audio did not change in time");
			@(negedge sys_clk);
			cycles++;
		end
	endtask

	task automatic measure_tone(input int p);
		int limit;
		int gap;
		limit = 2 * p * `SG_PSG_PRESCALE + 16;
		wait_change(limit, gap); // first edge may be left over from setup.
		repeat (2) begin
			wait_change(limit, gap);
			check_interval(gap, p * `SG_PSG_PRESCALE);
		end
	endtask

	initial begin
		entry_t e;
		void'($urandom(32'h438d35bd));
		req       = '0;
		req_valid = 1'b0;
		rsp_ready = 1'b0;
		joy_a     = 8'h00;
		joy_b     = 8'h00;
		bp_on     = 1'b0;
		arst_n    = 1'b0;
		build_table();
		repeat (2) @(posedge sys_clk);
		@(negedge sys_clk);
		arst_n = 1'b1;
		@(negedge sys_clk);
		if (!req_ready || rsp_valid)
			stop_run("bus handshake not idle after reset");
		foreach (stim_q[i]) begin
			e = stim_q[i];
			case (e.kind)
				K_BUS:   bus_cycle(e.req, e.val[7:0]);
				K_JOY: begin
					joy_a = e.val[15:8];
					joy_b = e.val[7:0];
				end
				K_BP:    bp_on = e.val[0];
				K_AUDIO: wait_audio(e.val[5:0]);
				K_TONE:  measure_tone(int'(e.val));
			endcase
		end
		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+design
design/sg_pkg.sv
design/sg_bus_decode.sv
design/sg_work_ram.sv
design/psg_regs.sv
design/psg_tone.sv
design/psg_mixer.sv
design/sg_top.sv
sim/sg_tb.sv
